//--- compile.f
+incdir+.
bt_timing_pkg.sv
bt_link_pkg.sv
bt_clock.sv
rx_bit_sampler.sv
sync_correlator.sv
link_ctrl.sv
bt_rx_top.sv
tb_bt_rx_top.sv

//--- Makefile
SIM = obj_dir/Vtb_bt_rx_top

$(SIM): compile.f bt_timing_pkg.sv bt_link_pkg.sv bt_clock.sv rx_bit_sampler.sv \
        sync_correlator.sv link_ctrl.sv bt_rx_top.sv tb_bt_rx_top.sv tb_bt_tasks.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_bt_rx_top -f compile.f -o Vtb_bt_rx_top

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- tb_bt_tasks.svh
`ifndef TB_BT_TASKS_SVH
`define TB_BT_TASKS_SVH

////////////////////
// helpers
////////////////////

// every task starts and ends 1 ns after a rising edge

task automatic compare(input logic [63:0] got, input logic [63:0] want, input string what);
  if (got !== want)
  begin
    error_count++;
    $display("[FAIL] %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, want);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  end
endtask

task automatic abort_run(input string what);
  $display("%0d ns: %s", $time, what);
  $display("TESTS FAILED");
  $fatal(1, "run aborted");
endtask

task automatic apply_reset();
  rstz = 1'b0;
  repeat (4) @(posedge clk_6M);
  #1;
  rstz = 1'b1;
endtask

task automatic pass_cycles(input int cycles);
  repeat (cycles) @(posedge clk_6M);
  #1;
endtask

// one-cycle pulse on a single one-shot
task automatic fire(input int which);
  case (which)
    os_page_enable:    page_scan_enable = 1'b1;
    os_page_cancel:    page_scan_cancel = 1'b1;
    os_inquiry_enable: inquiry_scan_enable = 1'b1;
    os_inquiry_cancel: inquiry_scan_cancel = 1'b1;
    default:           conn_detach = 1'b1;
  endcase
  pass_cycles(1);
  page_scan_enable    = 1'b0;
  page_scan_cancel    = 1'b0;
  inquiry_scan_enable = 1'b0;
  inquiry_scan_cancel = 1'b0;
  conn_detach         = 1'b0;
endtask

// lsb first, one bit per microsecond, line idles low afterwards
task automatic send_word(input syncword_t word);
  for (int i = 0; i < 64; i++)
  begin
    rxbit = word[i];
    pass_cycles(CYCLES_PER_US);
  end
  rxbit = 1'b0;
endtask

// flips exactly count distinct bits
function automatic syncword_t add_errors(input syncword_t word, input int count);
  syncword_t mask;
  int        pos;
  mask = '0;
  while ($countones(mask) < count)
  begin
    pos = $unsigned($random(seed)) % 64;
    mask[pos] = 1'b1;
  end
  return word ^ mask;
endfunction

task automatic wait_for_state(input link_state_t want, input int max_cycles, input string what);
  int n;
  n = 0;
  while (link_state !== want && n < max_cycles)
  begin
    pass_cycles(1);
    n++;
  end
  if (link_state !== want)
    abort_run($sformatf("link state never reached %s", what));
endtask

task automatic wait_for_scan(input logic level, input int max_cycles, input string what);
  int n;
  n = 0;
  while (scan_active !== level && n < max_cycles)
  begin
    pass_cycles(1);
    n++;
  end
  if (scan_active !== level)
    abort_run($sformatf("timed out waiting for %s", what));
endtask

task automatic wait_for_hits(input int want, input int max_cycles, input string what);
  int n;
  n = 0;
  while (hit_count < want && n < max_cycles)
  begin
    pass_cycles(1);
    n++;
  end
  if (hit_count < want)
    abort_run($sformatf("no inquiry hit for %s", what));
endtask

////////////////////
// directed tests
////////////////////

task automatic native_clock_count();
  compare(clkn, 0, "clkn after reset");
  compare(link_state, idle, "link state after reset");
  compare(scan_active, 0, "scan_active after reset");
  pass_cycles(4 * HALF_SLOT_CYCLES);
  compare(clkn, 4, "clkn after four half slots");
endtask

task automatic page_scan_to_connection();
  scan_interval = 16'd1;
  scan_window   = 16'd1;
  fire(os_page_enable);
  compare(link_state, page_scan, "state after page scan enable");
  compare(scan_active, 1, "scan_active in page scan");
  compare(hop_addr, my_hop, "hop address in page scan");
  send_word(syncword_dac);
  wait_for_state(connection, word_latency, "connection after the DAC word");
  compare(hop_addr, master_hop, "hop address in connection");
endtask

task automatic error_threshold_limits();
  send_word(add_errors(syncword_cac, thr_errors));
  pass_cycles(word_latency);
  compare(link_state, connection, "link after CAC with errors at threshold");
  fire(os_detach);
  compare(link_state, idle, "state after detach");
  fire(os_page_enable);
  compare(link_state, page_scan, "page scan re-entry");
  send_word(add_errors(syncword_dac, thr_errors + 1));
  pass_cycles(word_latency);
  compare(link_state, page_scan, "page scan after DAC with one error too many");
  // same code right at the limit still connects
  send_word(add_errors(syncword_dac, thr_errors));
  wait_for_state(connection, word_latency, "connection after DAC at threshold");
  fire(os_detach);
  compare(link_state, idle, "state after second detach");
endtask

task automatic inquiry_window_gating();
  int base;
  base          = hit_count;
  scan_interval = 16'd2;
  scan_window   = 16'd1;
  fire(os_inquiry_enable);
  compare(link_state, inquiry_scan, "state after inquiry scan enable");
  compare(hop_addr, giac_hop, "hop address in inquiry scan");
  compare(scan_active, 1, "window open at inquiry scan entry");
  wait_for_scan(1'b0, slot_cycles + 2, "the scan window to close");
  send_word(syncword_giac);
  pass_cycles(word_latency);
  compare(scan_active, 0, "word ended outside the window");
  compare(hit_count - base, 0, "inquiry hits outside the window");
  wait_for_scan(1'b1, slot_cycles + 2, "the scan window to reopen");
  send_word(syncword_giac);
  wait_for_hits(base + 1, word_latency, "a GIAC word inside the window");
  pass_cycles(word_latency);
  compare(hit_count - base, 1, "inquiry hits inside the window");
  compare(link_state, inquiry_scan, "state after inquiry hit");
endtask

task automatic cancel_and_detach();
  fire(os_page_cancel);
  compare(link_state, inquiry_scan, "page cancel during inquiry scan");
  fire(os_inquiry_cancel);
  compare(link_state, idle, "state after inquiry cancel");
  compare(scan_active, 0, "scan_active after inquiry cancel");
  fire(os_inquiry_cancel);
  compare(link_state, idle, "inquiry cancel in idle");
  scan_interval = 16'd1;
  scan_window   = 16'd1;
  fire(os_page_enable);
  compare(link_state, page_scan, "state after page scan enable");
  fire(os_inquiry_enable);
  compare(link_state, page_scan, "inquiry enable outside idle");
  fire(os_inquiry_cancel);
  compare(link_state, page_scan, "inquiry cancel during page scan");
  fire(os_detach);
  compare(link_state, page_scan, "detach during page scan");
  fire(os_page_cancel);
  compare(link_state, idle, "state after page cancel");
  compare(scan_active, 0, "scan_active after page cancel");
  fire(os_page_enable);
  send_word(syncword_dac);
  wait_for_state(connection, word_latency, "connection before detach");
  fire(os_page_cancel);
  compare(link_state, connection, "page cancel during connection");
  compare(scan_active, 0, "scan_active in connection");
  fire(os_detach);
  compare(link_state, idle, "state after detach");
  compare(hop_addr, my_hop, "hop address back in idle");
endtask

`endif

//--- tb_bt_rx_top.sv
`timescale 1ns/100ps

module tb_bt_rx_top;

  import bt_timing_pkg::*;
  import bt_link_pkg::*;

  localparam int clk_half_ns = 4;
  localparam int slot_cycles = 2 * HALF_SLOT_CYCLES;
  // two resync cycles and up to one tick in rx_sample before the last bit shifts in,
  // then 3 cycles to the state
  localparam int word_latency = 2 + CYCLES_PER_US + 3;
  localparam int word_cycles = 64 * CYCLES_PER_US + word_latency;
  localparam int thr_errors = 4;

  // clock count, two slot-edge waits, seven words, slack for the one-shots
  localparam int run_cycles = 4 * HALF_SLOT_CYCLES + 2 * (slot_cycles + 2)
                              + 7 * word_cycles + 200;
  localparam longint watchdog_ns = 2 * run_cycles * 2 * clk_half_ns;

  // hop addresses for the addresses set below, uap low nibble over the lap
  localparam hop_addr_t my_hop     = 28'hb3a_51c7;
  localparam hop_addr_t giac_hop   = 28'h09e_8b33;
  localparam hop_addr_t master_hop = 28'h66d_20f4;

  // one-shot selectors
  localparam int os_page_enable    = 0;
  localparam int os_page_cancel    = 1;
  localparam int os_inquiry_enable = 2;
  localparam int os_inquiry_cancel = 3;
  localparam int os_detach         = 4;

  logic        clk_6M = 1'b0;
  logic        rstz;
  logic        rxbit;
  logic        page_scan_enable;
  logic        page_scan_cancel;
  logic        inquiry_scan_enable;
  logic        inquiry_scan_cancel;
  logic        conn_detach;
  slot_cnt_t   scan_interval;
  slot_cnt_t   scan_window;
  corr_thr_t   corr_threshold;
  syncword_t   syncword_dac;
  syncword_t   syncword_giac;
  syncword_t   syncword_cac;
  bd_lap_t     my_lap;
  bd_lap_t     giac_lap;
  bd_lap_t     master_lap;
  bd_uap_t     my_uap;
  bd_uap_t     giac_uap;
  bd_uap_t     master_uap;
  clkn_t       clkn;
  link_state_t link_state;
  logic        scan_active;
  logic        inquiry_hit_p;
  hop_addr_t   hop_addr;

  int seed = 32'h78cd_36dd;
  int error_count = 0;
  int hit_count;

  always #(clk_half_ns) clk_6M = ~clk_6M;

  bt_rx_top #(
    .cycles_per_us (CYCLES_PER_US)
  ) bt_rx_top_inst (
    .clk_6M              (clk_6M),
    .rstz                (rstz),
    .rxbit               (rxbit),
    .page_scan_enable    (page_scan_enable),
    .page_scan_cancel    (page_scan_cancel),
    .inquiry_scan_enable (inquiry_scan_enable),
    .inquiry_scan_cancel (inquiry_scan_cancel),
    .conn_detach         (conn_detach),
    .scan_interval       (scan_interval),
    .scan_window         (scan_window),
    .corr_threshold      (corr_threshold),
    .syncword_dac        (syncword_dac),
    .syncword_giac       (syncword_giac),
    .syncword_cac        (syncword_cac),
    .my_lap              (my_lap),
    .giac_lap            (giac_lap),
    .master_lap          (master_lap),
    .my_uap              (my_uap),
    .giac_uap            (giac_uap),
    .master_uap          (master_uap),
    .clkn                (clkn),
    .link_state          (link_state),
    .scan_active         (scan_active),
    .inquiry_hit_p       (inquiry_hit_p),
    .hop_addr            (hop_addr)
  );

  // inquiry pulses last one full cycle, so the falling edge sees each once
  always @(negedge clk_6M)
  begin
    if (!rstz)
      hit_count <= 0;
    else if (inquiry_hit_p)
      hit_count <= hit_count + 1;
  end

  `include "tb_bt_tasks.svh"

  ////////////////////
  // sequence
  ////////////////////

  initial
  begin
    rstz                = 1'b0;
    rxbit               = 1'b0;
    page_scan_enable    = 1'b0;
    page_scan_cancel    = 1'b0;
    inquiry_scan_enable = 1'b0;
    inquiry_scan_cancel = 1'b0;
    conn_detach         = 1'b0;
    scan_interval       = 16'd1;
    scan_window         = 16'd1;
    corr_threshold      = 6'(thr_errors);
    syncword_dac        = 64'h9c3a_51e7_2b86_d40f;
    syncword_giac       = 64'h475c_c5ae_8b33_0f1d;
    syncword_cac        = 64'hb2d1_0e6f_93a4_78c5;
    my_lap              = 24'h3a_51c7;
    giac_lap            = 24'h9e_8b33;
    master_lap          = 24'h6d_20f4;
    my_uap              = 8'h5b;
    giac_uap            = 8'h00;
    master_uap          = 8'hc6;

    apply_reset();
    native_clock_count();
    page_scan_to_connection();
    error_threshold_limits();
    inquiry_window_gating();
    cancel_and_detach();

    if (error_count == 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("TESTS FAILED");
      $fatal(1, "%0d mismatches", error_count);
    end
  end

  // run limit
  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $fatal(1, "watchdog");
  end

endmodule

//--- bt_rx_top.sv
`timescale 1ns/100ps

module bt_rx_top #(
  parameter int cycles_per_us = bt_timing_pkg::CYCLES_PER_US
) (
  input  logic                      clk_6M,
  input  logic                      rstz,
  input  logic                      rxbit,
  input  logic                      page_scan_enable,
  input  logic                      page_scan_cancel,
  input  logic                      inquiry_scan_enable,
  input  logic                      inquiry_scan_cancel,
  input  logic                      conn_detach,
  input  bt_timing_pkg::slot_cnt_t  scan_interval,
  input  bt_timing_pkg::slot_cnt_t  scan_window,
  input  bt_link_pkg::corr_thr_t    corr_threshold,
  input  bt_link_pkg::syncword_t    syncword_dac,
  input  bt_link_pkg::syncword_t    syncword_giac,
  input  bt_link_pkg::syncword_t    syncword_cac,
  input  bt_link_pkg::bd_lap_t      my_lap,
  input  bt_link_pkg::bd_lap_t      giac_lap,
  input  bt_link_pkg::bd_lap_t      master_lap,
  input  bt_link_pkg::bd_uap_t      my_uap,
  input  bt_link_pkg::bd_uap_t      giac_uap,
  input  bt_link_pkg::bd_uap_t      master_uap,
  output bt_timing_pkg::clkn_t      clkn,
  output bt_link_pkg::link_state_t  link_state,
  output logic                      scan_active,
  output logic                      inquiry_hit_p,
  output bt_link_pkg::hop_addr_t    hop_addr
);

  import bt_link_pkg::*;

  logic      p_1us;
  logic      slot_p;
  logic      rx_sample;
  logic      corr_en;
  logic      sync_hit_p;
  syncword_t expected_word;

  ////////////////////
  // datapath
  ////////////////////

  bt_clock #(
    .cycles_per_us (cycles_per_us)
  ) bt_clock_inst (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .p_1us  (p_1us),
    .slot_p (slot_p),
    .clkn   (clkn)
  );

  rx_bit_sampler rx_bit_sampler_inst (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .rxbit     (rxbit),
    .p_1us     (p_1us),
    .rx_sample (rx_sample)
  );

  sync_correlator sync_correlator_inst (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .p_1us          (p_1us),
    .rx_sample      (rx_sample),
    .corr_en        (corr_en),
    .expected_word  (expected_word),
    .corr_threshold (corr_threshold),
    .sync_hit_p     (sync_hit_p)
  );

  ////////////////////
  // control
  ////////////////////

  link_ctrl link_ctrl_inst (
    .clk_6M              (clk_6M),
    .rstz                (rstz),
    .slot_p              (slot_p),
    .sync_hit_p          (sync_hit_p),
    .page_scan_enable    (page_scan_enable),
    .page_scan_cancel    (page_scan_cancel),
    .inquiry_scan_enable (inquiry_scan_enable),
    .inquiry_scan_cancel (inquiry_scan_cancel),
    .conn_detach         (conn_detach),
    .scan_interval       (scan_interval),
    .scan_window         (scan_window),
    .syncword_dac        (syncword_dac),
    .syncword_giac       (syncword_giac),
    .syncword_cac        (syncword_cac),
    .my_lap              (my_lap),
    .giac_lap            (giac_lap),
    .master_lap          (master_lap),
    .my_uap              (my_uap),
    .giac_uap            (giac_uap),
    .master_uap          (master_uap),
    .link_state          (link_state),
    .corr_en             (corr_en),
    .scan_active         (scan_active),
    .inquiry_hit_p       (inquiry_hit_p),
    .expected_word       (expected_word),
    .hop_addr            (hop_addr)
  );

endmodule

//--- link_ctrl.sv
`timescale 1ns/100ps

module link_ctrl (
  input  logic                      clk_6M,
  input  logic                      rstz,
  input  logic                      slot_p,
  input  logic                      sync_hit_p,
  input  logic                      page_scan_enable,
  input  logic                      page_scan_cancel,
  input  logic                      inquiry_scan_enable,
  input  logic                      inquiry_scan_cancel,
  input  logic                      conn_detach,
  input  bt_timing_pkg::slot_cnt_t  scan_interval,
  input  bt_timing_pkg::slot_cnt_t  scan_window,
  input  bt_link_pkg::syncword_t    syncword_dac,
  input  bt_link_pkg::syncword_t    syncword_giac,
  input  bt_link_pkg::syncword_t    syncword_cac,
  input  bt_link_pkg::bd_lap_t      my_lap,
  input  bt_link_pkg::bd_lap_t      giac_lap,
  input  bt_link_pkg::bd_lap_t      master_lap,
  input  bt_link_pkg::bd_uap_t      my_uap,
  input  bt_link_pkg::bd_uap_t      giac_uap,
  input  bt_link_pkg::bd_uap_t      master_uap,
  output bt_link_pkg::link_state_t  link_state,
  output logic                      corr_en,
  output logic                      scan_active,
  output logic                      inquiry_hit_p,
  output bt_link_pkg::syncword_t    expected_word,
  output bt_link_pkg::hop_addr_t    hop_addr
);

  import bt_timing_pkg::*;
  import bt_link_pkg::*;

  link_state_t state_nxt;
  slot_cnt_t   slot_cnt;
  logic [16:0] slot_cnt_inc;
  logic        in_scan;

  ////////////////////
  // state machine
  ////////////////////

  always_comb
  begin
    state_nxt = link_state;
    case (link_state)
      idle:
        if (page_scan_enable)
          state_nxt = page_scan;
        else if (inquiry_scan_enable)
          state_nxt = inquiry_scan;
      page_scan:
        if (page_scan_cancel)
          state_nxt = idle;
        else if (sync_hit_p)
          state_nxt = connection;
      inquiry_scan:
        if (inquiry_scan_cancel)
          state_nxt = idle;
      connection:
        if (conn_detach)
          state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      link_state <= idle;
    else
      link_state <= state_nxt;
  end

  // inquiry scan answers in place
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      inquiry_hit_p <= 1'b0;
    else
      inquiry_hit_p <= (link_state == inquiry_scan) & sync_hit_p;
  end

  ////////////////////
  // scan window
  ////////////////////

  assign in_scan      = (link_state == page_scan) || (link_state == inquiry_scan);
  assign slot_cnt_inc = {1'b0, slot_cnt} + 17'd1;

  // restarts on every state change, wraps at the interval
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cnt <= '0;
    else if (state_nxt != link_state)
      slot_cnt <= '0;
    else if (in_scan && slot_p)
    begin
      if (slot_cnt_inc >= {1'b0, scan_interval})
        slot_cnt <= '0;
      else
        slot_cnt <= slot_cnt_inc[15:0];
    end
  end

  assign scan_active = in_scan && (slot_cnt < scan_window);
  assign corr_en     = scan_active || (link_state == connection);

  ////////////////////
  // code and address select
  ////////////////////

  always_comb
  begin
    case (link_state)
      inquiry_scan:
      begin
        expected_word = syncword_giac;
        hop_addr      = {giac_uap[3:0], giac_lap};
      end
      connection:
      begin
        expected_word = syncword_cac;
        hop_addr      = {master_uap[3:0], master_lap};
      end
      // idle and page scan listen for our own address
      default:
      begin
        expected_word = syncword_dac;
        hop_addr      = {my_uap[3:0], my_lap};
      end
    endcase
  end

  property state_legal;
    @(posedge clk_6M) disable iff (!rstz)
      link_state inside {idle, page_scan, inquiry_scan, connection};
  endproperty

  a_state_legal : assert property (state_legal)
    else $error("link_state outside the legal set");

endmodule

//--- sync_correlator.sv
`timescale 1ns/100ps

module sync_correlator (
  input  logic                     clk_6M,
  input  logic                     rstz,
  input  logic                     p_1us,
  input  logic                     rx_sample,
  input  logic                     corr_en,
  input  bt_link_pkg::syncword_t   expected_word,
  input  bt_link_pkg::corr_thr_t   corr_threshold,
  output logic                     sync_hit_p
);

  import bt_link_pkg::*;

  localparam int word_w = $bits(syncword_t);
  localparam int cnt_w  = $clog2(word_w + 1);

  syncword_t        shift_reg;
  logic [cnt_w-1:0] sample_cnt;
  logic [cnt_w-1:0] mismatch_cnt;
  logic             word_full;
  logic             p_1us_d;
  logic             eval_p;

  // number of set bits in a word
  function automatic logic [cnt_w-1:0] count_ones(input syncword_t v);
    logic [cnt_w-1:0] n;
    n = '0;
    for (int i = 0; i < word_w; i++)
    begin
      n = n + cnt_w'(v[i]);
    end
    return n;
  endfunction

  ////////////////////
  // receive shift
  ////////////////////

  // newest bit at the top, lsb-first word lines up after 64 samples
  always_ff @(posedge clk_6M)
  begin
    if (p_1us)
      shift_reg <= {rx_sample, shift_reg[word_w-1:1]};
  end

  assign word_full = (sample_cnt == cnt_w'(word_w));

  // samples since corr_en rose, saturates at one word
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sample_cnt <= '0;
    else if (!corr_en || sync_hit_p)
      sample_cnt <= '0;
    else if (p_1us && !word_full)
      sample_cnt <= sample_cnt + 1'b1;
  end

  ////////////////////
  // compare
  ////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      p_1us_d <= 1'b0;
      eval_p  <= 1'b0;
    end
    else
    begin
      p_1us_d <= p_1us;
      eval_p  <= p_1us_d & corr_en & word_full;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (p_1us_d)
      mismatch_cnt <= count_ones(shift_reg ^ expected_word);
  end

  // two cycles after the tick that shifted the last bit in
  assign sync_hit_p = eval_p & corr_en & (mismatch_cnt <= {1'b0, corr_threshold});

  // a hit belongs to an enabled window and to a sample two cycles back
  property hit_needs_enable;
    @(posedge clk_6M) disable iff (!rstz)
      sync_hit_p |-> corr_en && $past(p_1us, 2);
  endproperty

  a_hit_needs_enable : assert property (hit_needs_enable)
    else $error("sync_hit_p without corr_en or out of step with p_1us");

endmodule

//--- rx_bit_sampler.sv
`timescale 1ns/100ps

module rx_bit_sampler (
  input  logic clk_6M,
  input  logic rstz,
  input  logic rxbit,
  input  logic p_1us,
  output logic rx_sample
);

  // two-stage guard against the asynchronous line
  logic [1:0] rxbit_meta;

  ////////////////////
  // resync
  ////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxbit_meta <= 2'b00;
    else
      rxbit_meta <= {rxbit_meta[0], rxbit};
  end

  ////////////////////
  // 1 us sample
  ////////////////////

  // holds its value between ticks
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_sample <= 1'b0;
    else if (p_1us)
      rx_sample <= rxbit_meta[1];
  end

endmodule

//--- bt_clock.sv
`timescale 1ns/100ps

module bt_clock #(
  parameter int cycles_per_us = bt_timing_pkg::CYCLES_PER_US
) (
  input  logic                 clk_6M,
  input  logic                 rstz,
  output logic                 p_1us,
  output logic                 slot_p,
  output bt_timing_pkg::clkn_t clkn
);

  import bt_timing_pkg::*;

  localparam int us_w = $clog2(cycles_per_us + 1);
  localparam int hs_w = $clog2(HALF_SLOT_CYCLES);

  logic [us_w-1:0] us_cnt;
  logic [hs_w-1:0] hs_cnt;
  logic            hs_end;

  ////////////////////
  // 1 us tick
  ////////////////////

  // high while the divider sits on its top value
  assign p_1us = (us_cnt == us_w'(cycles_per_us - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (p_1us)
      us_cnt <= '0;
    else
      us_cnt <= us_cnt + 1'b1;
  end

  ////////////////////
  // native clock
  ////////////////////

  // last cycle of a half slot
  assign hs_end = (hs_cnt == hs_w'(HALF_SLOT_CYCLES - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt <= '0;
      clkn   <= '0;
    end
    else if (hs_end)
    begin
      hs_cnt <= '0;
      clkn   <= clkn + 1'b1;
    end
    else
    begin
      hs_cnt <= hs_cnt + 1'b1;
    end
  end

  // odd clkn about to turn even, so a new slot starts
  assign slot_p = hs_end & clkn[0];

  // tick must stay a single-cycle strobe
  property p_1us_single;
    @(posedge clk_6M) disable iff (!rstz)
      p_1us |=> !p_1us;
  endproperty

  a_p_1us_single : assert property (p_1us_single)
    else $error("p_1us high on two consecutive cycles");

endmodule

//--- bt_link_pkg.sv
package bt_link_pkg;

  ////////////////////
  // link state
  ////////////////////

  typedef enum logic [1:0] {
    idle         = 2'd0,
    page_scan    = 2'd1,
    inquiry_scan = 2'd2,
    connection   = 2'd3
  } link_state_t;

  ////////////////////
  // access codes
  ////////////////////

  // full 64-bit sync word
  typedef logic [63:0] syncword_t;

  // allowed bit errors per sync word
  typedef logic [5:0] corr_thr_t;

  ////////////////////
  // device address
  ////////////////////

  typedef logic [23:0] bd_lap_t;
  typedef logic [7:0]  bd_uap_t;

  // uap[3:0] on top of the lap
  typedef logic [27:0] hop_addr_t;

endpackage

//--- bt_timing_pkg.sv
package bt_timing_pkg;

  ////////////////////
  // clock rates
  ////////////////////

  // clk_6M cycles in one microsecond
  localparam int CYCLES_PER_US = 6;

  // 312.5 us at 6 MHz
  localparam int HALF_SLOT_CYCLES = 1875;

  ////////////////////
  // clock types
  ////////////////////

  // native clock, one count per half slot
  typedef logic [27:0] clkn_t;

  // scan interval and window, in slots
  typedef logic [15:0] slot_cnt_t;

endpackage
